//--- Bender.yml
package:
  name: slideshow

sources:
  - files:
      - slide_pkg.sv
      - touch_pkg.sv
      - slide_state_if.sv
      - reset_sequencer.sv
      - gesture_debounce.sv
      - pixel_loader.sv
      - image_selector.sv
      - frame_addresser.sv
      - slideshow_top.sv
  - target: test
    files:
      - tb_slideshow.sv

//--- frame_addresser.sv
/* Read window follows the selected image only at frame boundaries.
   read_load also holds the read FIFO during memory reset and the flush window. */

`timescale 1ns/10ps

module frame_addresser import slide_pkg::*; (
	input  logic             CLOCK_33,
	input  logic             iRSTN,
	input  logic             new_frame,
	input  logic             end_frame,
	input  logic             mem_rst_n,
	input  logic             read_flush,
	slide_state_if.addresser state,
	output word_addr_t       read_base_addr,
	output word_addr_t       read_max_addr,
	output logic             read_load
);

	word_addr_t win_base;
	logic       new_frame_d;

	// First word of the selected image
	assign win_base = word_addr_t'(state.current_img) * word_addr_t'(WORDS_PER_IMAGE);

	// ==============================
	// Window latch and frame delay
	// ==============================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			read_base_addr <= '0;
			read_max_addr  <= word_addr_t'(WORDS_PER_IMAGE);
			new_frame_d    <= 1'b0;
		end else begin
			if (end_frame) begin
				read_base_addr <= win_base;
				read_max_addr  <= win_base + word_addr_t'(WORDS_PER_IMAGE);
			end
			// Reload the FIFO a cycle into each frame
			new_frame_d <= new_frame;
		end
	end

	// Reload strobe merged with memory reset and flush
	assign read_load = new_frame_d || !mem_rst_n || read_flush;

endmodule

//--- gesture_debounce.sv
/* One delayed pulse per accepted touch, then a lockout until the hold step.
   Touches during the lockout or while ctrl_rst is high are dropped. */

`timescale 1ns/10ps

module gesture_debounce import slide_pkg::*, touch_pkg::*; #(
	parameter gesture_e GESTURE = GESTURE_NONE
) (
	input  logic     CLOCK_33,
	input  logic     iRSTN,
	input  logic     ctrl_rst,
	input  logic     touch_ready,
	input  gesture_e gesture,
	output logic     pulse
);

	logic        active;
	logic        trigger;
	step_count_t count;

	// Touch report for this direction
	assign trigger = touch_ready && (gesture == GESTURE);

	// ==============================
	// Arm, count, rearm
	// ==============================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			active <= 1'b0;
			count  <= '0;
		end else if (ctrl_rst) begin
			// Held idle until control reset ends
			active <= 1'b0;
			count  <= '0;
		end else if (trigger && !active) begin
			active <= 1'b1;
		end else if (active && (count < step_count_t'(DEBOUNCE_HOLD))) begin
			count <= count + 1'b1;
		end else if (count >= step_count_t'(DEBOUNCE_HOLD)) begin
			// Lockout over
			active <= 1'b0;
			count  <= '0;
		end
	end

	// Single cycle at the fire step
	assign pulse = active && (count == step_count_t'(DEBOUNCE_FIRE));

endmodule

//--- image_selector.sv
/* Swipes step the displayed image only after loading completes.
   Counts above MAX_IMAGES are clipped; a zero count is never stepped. */

`timescale 1ns/10ps

module image_selector import slide_pkg::*; (
	input  logic            CLOCK_33,
	input  logic            iRSTN,
	slide_state_if.selector state
);

	img_count_t img_limit;
	img_index_t last_img;
	img_index_t cur_img;

	// Number of images the index can reach
	assign img_limit = (state.img_count > img_count_t'(MAX_IMAGES)) ?
		img_count_t'(MAX_IMAGES) : state.img_count;

	// Wrap point
	assign last_img = img_index_t'(img_limit - 1'b1);

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			cur_img <= '0;
		end else if (state.load_done) begin
			// Previous takes priority over next
			if (state.swipe_prev) begin
				if (cur_img == '0)
					cur_img <= last_img;
				else
					cur_img <= cur_img - 1'b1;
			end else if (state.swipe_next) begin
				if (cur_img == last_img)
					cur_img <= '0;
				else
					cur_img <= cur_img + 1'b1;
			end
		end
	end

	assign state.current_img = cur_img;

endmodule

//--- pixel_loader.sv
/* Counts pixel strobes up to img_count images; a zero count never completes.
   Strobes beyond the announced total are ignored. */

`timescale 1ns/10ps

module pixel_loader import slide_pkg::*; (
	input  logic           CLOCK_33,
	input  logic           iRSTN,
	input  logic           pixel_strobe,
	slide_state_if.loader  state,
	output logic           loading
);

	pixel_count_t  pix_count;
	pixel_count_t  pix_total;
	settle_count_t settle_cnt;
	logic          done;

	// Pixels expected for the whole slideshow
	assign pix_total = pixel_count_t'(state.img_count) * pixel_count_t'(PIXELS_PER_IMAGE);

	// Complete once the count meets a nonzero total
	assign done = (state.img_count != '0) && (pix_count == pix_total);
	assign state.load_done = done;

	// ==============================
	// Pixel counter
	// ==============================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			pix_count <= '0;
		end else if (pixel_strobe && (pix_count < pix_total)) begin
			pix_count <= pix_count + 1'b1;
		end
	end

	// ==============================
	// Loading level
	// ==============================

	// Up after the first pixel, down a settle delay after completion
	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			loading    <= 1'b0;
			settle_cnt <= '0;
		end else if (done) begin
			if (settle_cnt < settle_count_t'(LOAD_SETTLE_CYCLES - 1))
				settle_cnt <= settle_cnt + 1'b1;
			else
				loading <= 1'b0;
		end else if (pix_count != '0) begin
			loading <= 1'b1;
		end
	end

endmodule

//--- reset_sequencer.sv
/* Staged release after iRSTN: memory first, then a read flush, then control.
   Step counts come from the package and the counter saturates at the last one. */

`timescale 1ns/10ps

module reset_sequencer import slide_pkg::*; (
	input  logic CLOCK_33,
	input  logic iRSTN,
	output logic mem_rst_n,
	output logic read_flush,
	output logic ctrl_rst
);

	// Named phases of the sequence
	// SEQ_RUN here is the phase; the package step count is used scoped
	typedef enum logic [1:0] {
		SEQ_HOLD,
		SEQ_WAKE,
		SEQ_FLUSH,
		SEQ_RUN
	} seq_state_e;

	step_count_t step_cnt;
	seq_state_e  phase;

	// ==============================
	// Step counter
	// ==============================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			step_cnt <= '0;
		end else if (step_cnt < step_count_t'(slide_pkg::SEQ_RUN)) begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

	// Phase decode from the step count
	always_comb begin
		if (step_cnt < step_count_t'(SEQ_MEM_RELEASE))
			phase = SEQ_HOLD;
		else if (step_cnt < step_count_t'(SEQ_FLUSH_START))
			phase = SEQ_WAKE;
		else if (step_cnt < step_count_t'(slide_pkg::SEQ_RUN))
			phase = SEQ_FLUSH;
		else
			phase = SEQ_RUN;
	end

	// Memory leaves reset after the hold phase
	assign mem_rst_n  = (phase != SEQ_HOLD);

	// Read side emptied just before control starts
	assign read_flush = (phase == SEQ_FLUSH);

	// Control logic held until the sequence ends
	assign ctrl_rst   = (phase != SEQ_RUN);

endmodule

//--- slide_pkg.sv
/* Frame, image and reset-sequence constants are scaled for simulation.
   Restore 384000 pixels and a 2^26 step sequence here for hardware. */

package slide_pkg;

	// ==============================
	// Image geometry
	// ==============================

	// Pixel strobes per image (800x480 on the board)
	localparam int PIXELS_PER_IMAGE = 128;

	// Memory bus is 16 bits, so two words per 32-bit pixel
	localparam int WORDS_PER_IMAGE = 2 * PIXELS_PER_IMAGE;

	// Largest slideshow the 5-bit index can address
	localparam int MAX_IMAGES = 32;

	// Cycles from load complete until loading drops
	localparam int LOAD_SETTLE_CYCLES = 52;

	// ==============================
	// Reset sequence steps
	// ==============================

	localparam int SEQ_MEM_RELEASE = 16;  // memory reset released
	localparam int SEQ_FLUSH_START = 32;  // read FIFO flush begins
	localparam int SEQ_RUN         = 64;  // control reset released

	// Types shared across the datapath
	typedef logic [4:0]  img_index_t;
	typedef logic [7:0]  img_count_t;
	typedef logic [23:0] word_addr_t;
	typedef logic [31:0] pixel_count_t;

	// Step counter for timed sequences, wide enough for SEQ_RUN
	typedef logic [7:0] step_count_t;

	// Settle delay counter
	typedef logic [$clog2(LOAD_SETTLE_CYCLES + 1) - 1:0] settle_count_t;

endpackage

//--- slide_state_if.sv
/* Slideshow state shared between loader, selector and addresser.
   All signals are plain levels or one-cycle pulses on CLOCK_33. */

`timescale 1ns/10ps

interface slide_state_if import slide_pkg::*; ();

	// Number of images announced by the host
	img_count_t img_count;

	// High once every pixel of every image has arrived
	logic load_done;

	// One-cycle swipe pulses from the debouncers
	logic swipe_prev;
	logic swipe_next;

	// Image on display
	img_index_t current_img;

	// Pixel counting side
	modport loader (
		input  img_count,
		output load_done
	);

	// Index stepping side
	modport selector (
		input  img_count, load_done, swipe_prev, swipe_next,
		output current_img
	);

	// Read window side
	modport addresser (
		input current_img
	);

endinterface

//--- slideshow_top.sv
/* Slideshow control core on a single CLOCK_33 domain; no input synchronizers.
   Pixel strobes, touch reports and frame events are never refused. */

`timescale 1ns/10ps

module slideshow_top import slide_pkg::*, touch_pkg::*; (
	input  logic       CLOCK_33,
	input  logic       iRSTN,

	// Host pixel stream
	input  logic       pixel_strobe,
	input  img_count_t img_count,

	// Touch panel report
	input  logic       touch_ready,
	input  gesture_e   gesture,

	// Display timing events
	input  logic       new_frame,
	input  logic       end_frame,

	// Status and display side
	output logic       loading,
	output logic       display_rst_n,
	output img_index_t current_img,

	// Memory read side
	output logic       read_load,
	output logic       mem_rst_n,
	output word_addr_t read_base_addr,
	output word_addr_t read_max_addr
);

	logic read_flush;
	logic ctrl_rst;
	logic pulse_east;
	logic pulse_west;

	slide_state_if state_bus ();

	// ==============================
	// Reset staging
	// ==============================

	reset_sequencer u_reset_sequencer (
		.CLOCK_33   (CLOCK_33),
		.iRSTN      (iRSTN),
		.mem_rst_n  (mem_rst_n),
		.read_flush (read_flush),
		.ctrl_rst   (ctrl_rst)
	);

	// Display runs once control reset drops
	assign display_rst_n = ~ctrl_rst;

	// ==============================
	// Loading and selection
	// ==============================

	assign state_bus.img_count = img_count;

	pixel_loader u_pixel_loader (
		.CLOCK_33     (CLOCK_33),
		.iRSTN        (iRSTN),
		.pixel_strobe (pixel_strobe),
		.state        (state_bus.loader),
		.loading      (loading)
	);

	// East swipe goes back one slide
	gesture_debounce #(.GESTURE(GESTURE_EAST)) debounce_east (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.ctrl_rst    (ctrl_rst),
		.touch_ready (touch_ready),
		.gesture     (gesture),
		.pulse       (pulse_east)
	);

	// West swipe goes forward one slide
	gesture_debounce #(.GESTURE(GESTURE_WEST)) debounce_west (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.ctrl_rst    (ctrl_rst),
		.touch_ready (touch_ready),
		.gesture     (gesture),
		.pulse       (pulse_west)
	);

	assign state_bus.swipe_prev = pulse_east;
	assign state_bus.swipe_next = pulse_west;

	image_selector u_image_selector (
		.CLOCK_33 (CLOCK_33),
		.iRSTN    (iRSTN),
		.state    (state_bus.selector)
	);

	assign current_img = state_bus.current_img;

	// ==============================
	// Read window
	// ==============================

	frame_addresser u_frame_addresser (
		.CLOCK_33       (CLOCK_33),
		.iRSTN          (iRSTN),
		.new_frame      (new_frame),
		.end_frame      (end_frame),
		.mem_rst_n      (mem_rst_n),
		.read_flush     (read_flush),
		.state          (state_bus.addresser),
		.read_base_addr (read_base_addr),
		.read_max_addr  (read_max_addr),
		.read_load      (read_load)
	);

endmodule

//--- tb.f
slide_pkg.sv
touch_pkg.sv
slide_state_if.sv
reset_sequencer.sv
gesture_debounce.sv
pixel_loader.sv
image_selector.sv
frame_addresser.sv
slideshow_top.sv
tb_slideshow.sv

//--- tb_slideshow.sv
/* Directed testbench for slideshow_top with the scaled package constants.
   Expects img_count 3 and relies on the debounce lockout between touches. */

`timescale 1ns/10ps

module tb_slideshow import slide_pkg::*, touch_pkg::*; ();

	// Upper bound on the run in clock cycles
	// Three images of pixels with gaps of up to 4 cycles is about 1600,
	// reset, swipes and frames add about 1000 more
	localparam int TIMEOUT_CYCLES = 10000;

	logic       CLOCK_33;
	logic       iRSTN;
	logic       pixel_strobe;
	img_count_t img_count;
	logic       touch_ready;
	gesture_e   gesture;
	logic       new_frame;
	logic       end_frame;
	logic       loading;
	logic       display_rst_n;
	img_index_t current_img;
	logic       read_load;
	logic       mem_rst_n;
	word_addr_t read_base_addr;
	word_addr_t read_max_addr;

	int          cycle_count = 0;
	int unsigned lcg_state   = 43;

	slideshow_top dut (
		.CLOCK_33       (CLOCK_33),
		.iRSTN          (iRSTN),
		.pixel_strobe   (pixel_strobe),
		.img_count      (img_count),
		.touch_ready    (touch_ready),
		.gesture        (gesture),
		.new_frame      (new_frame),
		.end_frame      (end_frame),
		.loading        (loading),
		.display_rst_n  (display_rst_n),
		.current_img    (current_img),
		.read_load      (read_load),
		.mem_rst_n      (mem_rst_n),
		.read_base_addr (read_base_addr),
		.read_max_addr  (read_max_addr)
	);

	// 8 ns period
	initial begin
		CLOCK_33 = 1'b0;
		forever #4 CLOCK_33 = ~CLOCK_33;
	end

	// ==============================
	// Failure reporting
	// ==============================

	task automatic end_with_failure();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// Event that never came
	task automatic missed_event(input string what);
		$display("Error at %0t ns: %s", $time, what);
		end_with_failure();
	endtask

	task automatic check_index(input img_index_t actual, input img_index_t expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			end_with_failure();
		end
	endtask

	task automatic check_addr(input word_addr_t actual, input word_addr_t expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is 0x%06h, expected 0x%06h", $time, what, actual,
				expected);
			end_with_failure();
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			end_with_failure();
		end
	endtask

	// Run limit
	always @(posedge CLOCK_33) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
			end_with_failure();
		end
	end

	// ==============================
	// Stimulus helpers
	// ==============================

	// LCG for pixel gaps
	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// One touch report, one cycle wide
	task automatic send_touch(input gesture_e code);
		@(posedge CLOCK_33);
		touch_ready <= 1'b1;
		gesture     <= code;
		@(posedge CLOCK_33);
		touch_ready <= 1'b0;
		gesture     <= GESTURE_NONE;
	endtask

	// Waits for current_img to leave from_img, then checks where it went
	task automatic wait_step(input img_index_t from_img, input img_index_t expected);
		int n;
		n = 0;
		while (current_img === from_img) begin
			@(negedge CLOCK_33);
			n++;
			if (n > DEBOUNCE_FIRE + 8)
				missed_event("current_img did not change after a swipe");
		end
		check_index(current_img, expected, "current_img after swipe");
	endtask

	task automatic swipe_step(input gesture_e code, input img_index_t expected);
		img_index_t start;
		start = current_img;
		send_touch(code);
		wait_step(start, expected);
		// Let the lockout run out before the next touch
		repeat (DEBOUNCE_HOLD) @(posedge CLOCK_33);
	endtask

	// Window latched on the edge that samples end_frame
	task automatic pulse_end_frame();
		@(posedge CLOCK_33);
		end_frame <= 1'b1;
		@(posedge CLOCK_33);
		end_frame <= 1'b0;
		@(negedge CLOCK_33);
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_reset();
		int n;
		@(negedge CLOCK_33);
		check_bit(mem_rst_n, 1'b0, "mem_rst_n after reset");
		check_bit(read_load, 1'b1, "read_load after reset");
		check_bit(display_rst_n, 1'b0, "display_rst_n after reset");
		check_bit(loading, 1'b0, "loading after reset");
		check_index(current_img, '0, "current_img after reset");
		check_addr(read_base_addr, '0, "read_base_addr after reset");
		check_addr(read_max_addr, word_addr_t'(WORDS_PER_IMAGE), "read_max_addr after reset");
		// Memory held, FIFO load held with it
		n = 0;
		while (mem_rst_n !== 1'b1) begin
			check_bit(read_load, 1'b1, "read_load while memory in reset");
			@(negedge CLOCK_33);
			n++;
			if (n > SEQ_RUN)
				missed_event("mem_rst_n never rose after reset");
		end
		// Flush window shows up as read_load
		n = 0;
		while (read_load !== 1'b1) begin
			@(negedge CLOCK_33);
			n++;
			if (n > SEQ_RUN)
				missed_event("read_load never rose during the flush window");
		end
		check_bit(mem_rst_n, 1'b1, "mem_rst_n during flush");
		n = 0;
		while (display_rst_n !== 1'b1) begin
			@(negedge CLOCK_33);
			n++;
			if (n > SEQ_RUN)
				missed_event("display_rst_n never rose");
		end
		check_bit(read_load, 1'b0, "read_load after flush");
		repeat (20) begin
			@(negedge CLOCK_33);
			check_bit(display_rst_n, 1'b1, "display_rst_n after sequence");
		end
	endtask

	// Swipe before load complete must not move the index
	task automatic test_gesture_gating();
		check_bit(loading, 1'b0, "loading before any pixel");
		send_touch(GESTURE_WEST);
		repeat (DEBOUNCE_HOLD + 10) begin
			@(negedge CLOCK_33);
			check_index(current_img, '0, "current_img before load complete");
		end
	endtask

	task automatic test_loading();
		int sent;
		int gap;
		int n;
		for (sent = 0; sent < 3 * PIXELS_PER_IMAGE; sent++) begin
			@(posedge CLOCK_33);
			pixel_strobe <= 1'b1;
			@(posedge CLOCK_33);
			pixel_strobe <= 1'b0;
			gap = next_rand() % 4;
			repeat (gap) @(posedge CLOCK_33);
			@(negedge CLOCK_33);
			if (sent > 0)
				check_bit(loading, 1'b1, "loading during transfer");
		end
		// Settle delay after the last pixel
		n = 0;
		while (loading !== 1'b0) begin
			@(negedge CLOCK_33);
			n++;
			if (n > LOAD_SETTLE_CYCLES + 8)
				missed_event("loading did not fall after the last pixel");
		end
		check_bit(n >= LOAD_SETTLE_CYCLES - 8, 1'b1, "loading held through settle delay");
	endtask

	task automatic test_swipe_stepping();
		swipe_step(GESTURE_WEST, 5'd1);
		swipe_step(GESTURE_WEST, 5'd2);
		swipe_step(GESTURE_WEST, 5'd0);
		// Back from the first image wraps to the last
		swipe_step(GESTURE_EAST, 5'd2);
	endtask

	// Second touch inside the lockout is dropped
	task automatic test_double_swipe();
		send_touch(GESTURE_WEST);
		wait_step(5'd2, 5'd0);
		// Past the fire step but short of the hold step
		send_touch(GESTURE_WEST);
		repeat (DEBOUNCE_HOLD + 10) begin
			@(negedge CLOCK_33);
			check_index(current_img, 5'd0, "current_img after double swipe");
		end
	endtask

	task automatic test_frame_window();
		swipe_step(GESTURE_WEST, 5'd1);
		pulse_end_frame();
		check_addr(read_base_addr, word_addr_t'(1 * WORDS_PER_IMAGE), "read_base_addr image 1");
		check_addr(read_max_addr, word_addr_t'(2 * WORDS_PER_IMAGE), "read_max_addr image 1");
		// FIFO reload one cycle into the frame
		check_bit(read_load, 1'b0, "read_load before new_frame");
		@(posedge CLOCK_33);
		new_frame <= 1'b1;
		@(posedge CLOCK_33);
		new_frame <= 1'b0;
		@(negedge CLOCK_33);
		check_bit(read_load, 1'b1, "read_load after new_frame");
		@(negedge CLOCK_33);
		check_bit(read_load, 1'b0, "read_load a cycle later");
		// No end_frame, window stays on image 1
		swipe_step(GESTURE_WEST, 5'd2);
		check_addr(read_base_addr, word_addr_t'(1 * WORDS_PER_IMAGE), "read_base_addr held");
		check_addr(read_max_addr, word_addr_t'(2 * WORDS_PER_IMAGE), "read_max_addr held");
		pulse_end_frame();
		check_addr(read_base_addr, word_addr_t'(2 * WORDS_PER_IMAGE), "read_base_addr image 2");
		check_addr(read_max_addr, word_addr_t'(3 * WORDS_PER_IMAGE), "read_max_addr image 2");
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		iRSTN        = 1'b0;
		pixel_strobe = 1'b0;
		img_count    = 8'd3;
		touch_ready  = 1'b0;
		gesture      = GESTURE_NONE;
		new_frame    = 1'b0;
		end_frame    = 1'b0;
		repeat (5) @(posedge CLOCK_33);
		iRSTN <= 1'b1;
		test_reset();
		test_gesture_gating();
		test_loading();
		test_swipe_stepping();
		test_double_swipe();
		test_frame_window();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- touch_pkg.sv
/* Gesture codes follow the touch controller register map.
   Debounce steps are scaled; the board used 10 M and 25 M cycles. */

package touch_pkg;

	// Gesture register codes from the touch panel
	typedef enum logic [7:0] {
		GESTURE_NONE = 8'h00,
		GESTURE_EAST = 8'h14,
		GESTURE_WEST = 8'h1C
	} gesture_e;

	// ==============================
	// Debounce timing
	// ==============================

	// Step at which the delayed pulse fires
	localparam int DEBOUNCE_FIRE = 20;

	// Step at which the unit accepts a new touch
	// Keeps one swipe from skipping two slides
	localparam int DEBOUNCE_HOLD = 50;

endpackage
